// ==== src/cpu16_alu.sv ====
// ----------------------------------------------------------
// combinational alu for register operations, compare flags
// and selection of one flag into status bit 0
// ----------------------------------------------------------
module cpu16_alu (
  input  cpu16_pkg::alu_op_t alu_op,
  input  cpu16_pkg::word_t   a,
  input  cpu16_pkg::word_t   b,
  input  cpu16_pkg::word_t   status,
  output cpu16_pkg::word_t   result
);
  import cpu16_pkg::*;

  flags_t flags;

  // unsigned compare, eq in bit 0
  assign flags = {a <= b, a < b, a >= b, a > b, a != b, a == b};

  always_comb begin
    case (alu_op)
      ALU_MOVE:   result = a;                   // written to reg b
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SHL:    result = a << b;              // 16 or more gives zero
      ALU_SHR:    result = a >> b;
      ALU_CMP:    result = {{(WORD_BITS - $bits(flags_t)){1'b0}}, flags};
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_NOT:    result = ~a;
      ALU_LNOT:   result = {{(WORD_BITS - 1){1'b0}}, a == '0};
      ALU_SHL1:   result = a << 1;
      ALU_SHR1:   result = a >> 1;
      ALU_ROL1:   result = {a[WORD_BITS-2:0], a[WORD_BITS-1]};
      ALU_ROR1:   result = {a[0], a[WORD_BITS-1:1]};
      ALU_SEL_EQ: result = {status[WORD_BITS-1:1], status[0]};
      ALU_SEL_NE: result = {status[WORD_BITS-1:1], status[1]};
      ALU_SEL_GT: result = {status[WORD_BITS-1:1], status[2]};
      ALU_SEL_GE: result = {status[WORD_BITS-1:1], status[3]};
      ALU_SEL_LT: result = {status[WORD_BITS-1:1], status[4]};
      ALU_SEL_LE: result = {status[WORD_BITS-1:1], status[5]};
      default:    result = b;                   // pass
    endcase
  end

endmodule

// ==== src/cpu16_control.sv ====
// ----------------------------------------------------------
// instruction-cycle fsm, sequences fetch, immediate load,
// execute and memory writes, drives the register write port
// and the request/acknowledge memory bus
// ----------------------------------------------------------
module cpu16_control (
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    mem_ack,
  input  cpu16_pkg::word_t        mem_rdata,
  output logic                    mem_req,
  output logic                    mem_write,
  output cpu16_pkg::addr_t        mem_addr,
  output cpu16_pkg::word_t        mem_wdata,
  output cpu16_pkg::word_t        instr,
  output logic                    halted,
  input  cpu16_pkg::instr_class_t instr_class,
  input  logic                    has_imm,
  input  cpu16_pkg::reg_idx_t     reg_a,
  input  cpu16_pkg::reg_idx_t     reg_b,
  input  cpu16_pkg::alu_op_t      alu_op,
  input  logic [4:0]              op_code,
  input  logic                    illegal,
  input  cpu16_pkg::word_t        alu_result,
  output cpu16_pkg::reg_idx_t     rd_idx_a,
  output cpu16_pkg::reg_idx_t     rd_idx_b,
  output logic                    wr_en,
  output cpu16_pkg::reg_idx_t     wr_idx,
  output cpu16_pkg::word_t        wr_data,
  input  cpu16_pkg::word_t        rd_data_a,
  input  cpu16_pkg::word_t        rd_data_b,
  input  cpu16_pkg::word_t        pc,
  input  cpu16_pkg::word_t        sp
);
  import cpu16_pkg::*;

  cycle_t state, next_state;
  logic   sub, next_sub;          // request / wait half
  word_t  imm, next_imm;          // word after the instruction
  word_t  next_instr;
  logic   next_req, next_write;
  addr_t  next_addr;
  word_t  next_wdata;

  assign halted   = (state == HALT);
  assign rd_idx_a = reg_a;
  assign rd_idx_b = (instr_class == CLS_ONE_REG) ? STATUS_IDX : reg_b;  // jump-if flag

  // ----------------------------------------------------------
  // next state and register write port
  // ----------------------------------------------------------
  always_comb begin
    next_state = state;
    next_sub   = sub;
    next_instr = instr;
    next_imm   = imm;
    next_req   = 1'b0;                // read requests are one-cycle pulses
    next_write = mem_write;
    next_addr  = mem_addr;            // held until ack
    next_wdata = mem_wdata;
    wr_en      = 1'b0;
    wr_idx     = reg_a;
    wr_data    = alu_result;

    case (state)
      FETCH, LOAD_IMM: begin
        if (!sub) begin               // request word at pc, step pc
          next_req  = 1'b1;
          next_addr = pc;
          next_sub  = 1'b1;
          wr_en     = 1'b1;
          wr_idx    = IP_IDX;
          wr_data   = pc + 1'b1;
        end else if (mem_ack) begin
          next_sub = 1'b0;
          if (state == FETCH) begin
            next_instr = mem_rdata;
            next_state = DECODE;
          end else begin
            next_imm   = mem_rdata;
            next_state = EXEC;
          end
        end
      end

      DECODE: begin
        if (illegal)      next_state = HALT;      // unknown opcode
        else if (has_imm) next_state = LOAD_IMM;
        else              next_state = EXEC;
      end

      EXEC: begin
        if (sub) begin                // waiting for load or pop data
          if (mem_ack) begin
            wr_en      = 1'b1;
            wr_data    = mem_rdata;
            next_sub   = 1'b0;
            next_state = FETCH;
          end
        end else begin
          next_state = FETCH;         // most ops finish in one cycle
          case (instr_class)
            CLS_TWO_REG: begin
              wr_en = 1'b1;
              if (alu_op == ALU_MOVE)     wr_idx = reg_b;
              else if (alu_op == ALU_CMP) wr_idx = STATUS_IDX;
            end
            CLS_ONE_REG: begin
              if (has_imm) begin
                case (op_code)
                  OPC_IMM_LOAD: begin
                    wr_en   = 1'b1;
                    wr_data = imm;
                  end
                  OPC_MEM_LOAD: begin
                    next_req   = 1'b1;
                    next_addr  = imm;
                    next_sub   = 1'b1;
                    next_state = EXEC;
                  end
                  default: begin      // store
                    next_req   = 1'b1;
                    next_write = 1'b1;
                    next_addr  = imm;
                    next_wdata = rd_data_a;
                    next_state = WRITE_MEM;
                  end
                endcase
              end else begin
                case (op_code)
                  OPC_JMP_IF: begin
                    wr_en   = rd_data_b[0];   // status bit 0
                    wr_idx  = IP_IDX;
                    wr_data = rd_data_a;
                  end
                  OPC_JMP: begin
                    wr_en   = 1'b1;
                    wr_idx  = IP_IDX;
                    wr_data = rd_data_a;
                  end
                  OPC_JMP_REL: begin
                    wr_en   = 1'b1;
                    wr_idx  = IP_IDX;
                    wr_data = pc + rd_data_a;   // pc already past instr
                  end
                  OPC_PUSH: begin
                    wr_en      = 1'b1;
                    wr_idx     = SP_IDX;
                    wr_data    = sp - 1'b1;
                    next_req   = 1'b1;
                    next_write = 1'b1;
                    next_addr  = sp - 1'b1;
                    next_wdata = rd_data_a;
                    next_state = WRITE_MEM;
                  end
                  OPC_POP: begin
                    wr_en      = 1'b1;
                    wr_idx     = SP_IDX;
                    wr_data    = sp + 1'b1;
                    next_req   = 1'b1;
                    next_addr  = sp;
                    next_sub   = 1'b1;
                    next_state = EXEC;
                  end
                  default: wr_en = 1'b1;      // not, lnot, shifts, rotates
                endcase
              end
            end
            default: begin
              case (op_code)
                OPC_HALT: next_state = HALT;
                OPC_NOP:  next_state = FETCH;
                default: begin              // flag selects
                  wr_en  = 1'b1;
                  wr_idx = STATUS_IDX;
                end
              endcase
            end
          endcase
        end
      end

      WRITE_MEM: begin
        next_req = 1'b1;              // hold until ack
        if (mem_ack) begin
          next_req   = 1'b0;
          next_write = 1'b0;
          next_state = FETCH;
        end
      end

      default: next_state = HALT;     // stays until reset
    endcase
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state     <= FETCH;
      sub       <= 1'b0;
      instr     <= '0;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      state     <= next_state;
      sub       <= next_sub;
      instr     <= next_instr;
      mem_req   <= next_req;
      mem_write <= next_write;
    end
  end

  always_ff @(posedge in_clk) begin
    imm       <= next_imm;
    mem_addr  <= next_addr;
    mem_wdata <= next_wdata;
  end

endmodule

// ==== src/cpu16_decoder.sv ====
// ----------------------------------------------------------
// combinational instruction decoder, splits the latched word
// into class, register fields, alu operation and raw opcode
// ----------------------------------------------------------
module cpu16_decoder (
  input  cpu16_pkg::word_t        instr,
  output cpu16_pkg::instr_class_t instr_class,
  output logic                    has_imm,
  output cpu16_pkg::reg_idx_t     reg_a,
  output cpu16_pkg::reg_idx_t     reg_b,
  output cpu16_pkg::alu_op_t      alu_op,
  output logic [4:0]              op_code,
  output logic                    illegal
);
  import cpu16_pkg::*;

  always_comb begin
    has_imm = instr[IMM_BIT];
    alu_op  = ALU_PASS;               // jumps, memory, nop, halt
    illegal = 1'b0;
    reg_a   = instr[3:0];
    reg_b   = '0;
    if (instr[WORD_BITS-1]) begin
      instr_class = CLS_TWO_REG;
      has_imm     = 1'b0;             // bit 13 is reserved here
      reg_a       = instr[7:4];
      reg_b       = instr[3:0];
      op_code     = {1'b0, instr[11:8]};
      case (op_code)
        OPC_MOVE: alu_op = ALU_MOVE;
        OPC_ADD:  alu_op = ALU_ADD;
        OPC_SUB:  alu_op = ALU_SUB;
        OPC_SHL:  alu_op = ALU_SHL;
        OPC_SHR:  alu_op = ALU_SHR;
        OPC_CMP:  alu_op = ALU_CMP;
        OPC_AND:  alu_op = ALU_AND;
        OPC_OR:   alu_op = ALU_OR;
        default:  illegal = 1'b1;     // mul, div, rem and beyond
      endcase
    end else if (instr[WORD_BITS-2]) begin
      instr_class = CLS_ONE_REG;
      op_code     = {1'b0, instr[7:4]};
      if (has_imm) begin
        case (op_code)
          OPC_IMM_LOAD, OPC_MEM_LOAD, OPC_MEM_STORE: illegal = 1'b0;
          default: illegal = 1'b1;
        endcase
      end else begin
        case (op_code)
          OPC_JMP_IF, OPC_JMP, OPC_JMP_REL, OPC_PUSH, OPC_POP: alu_op = ALU_PASS;
          OPC_NOT:  alu_op = ALU_NOT;
          OPC_LNOT: alu_op = ALU_LNOT;
          OPC_SHL1: alu_op = ALU_SHL1;
          OPC_SHR1: alu_op = ALU_SHR1;
          OPC_ROL1: alu_op = ALU_ROL1;
          OPC_ROR1: alu_op = ALU_ROR1;
          default:  illegal = 1'b1;   // call lands here too
        endcase
      end
    end else begin
      instr_class = CLS_ZERO_REG;
      reg_a       = '0;
      op_code     = instr[4:0];
      case (op_code)
        OPC_HALT, OPC_NOP: alu_op = ALU_PASS;
        OPC_SEL_EQ: alu_op = ALU_SEL_EQ;
        OPC_SEL_NE: alu_op = ALU_SEL_NE;
        OPC_SEL_GT: alu_op = ALU_SEL_GT;
        OPC_SEL_GE: alu_op = ALU_SEL_GE;
        OPC_SEL_LT: alu_op = ALU_SEL_LT;
        OPC_SEL_LE: alu_op = ALU_SEL_LE;
        default:    illegal = 1'b1;
      endcase
      if (has_imm) illegal = 1'b1;    // no zero-reg immediate forms
    end
  end

endmodule

// ==== src/cpu16_pkg.sv ====
// ----------------------------------------------------------
// shared widths, register indices, opcodes and enums of the
// 16-bit multicycle cpu, imported by every rtl module
// ----------------------------------------------------------
package cpu16_pkg;

  localparam int WORD_BITS = 16;
  localparam int ADDR_BITS = 16;
  localparam int NUM_REGS  = 16;
  localparam int IMM_BIT   = 13;            // immediate word follows

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [3:0]           reg_idx_t;
  typedef logic [5:0]           flags_t;    // eq ne gt ge lt le, bit 0 first

  localparam reg_idx_t IP_IDX     = 4'd12;  // instruction pointer
  localparam reg_idx_t SP_IDX     = 4'd13;  // stack pointer
  localparam reg_idx_t STATUS_IDX = 4'd15;  // compare flags

  typedef enum logic [1:0] {
    CLS_ZERO_REG = 2'b00,
    CLS_ONE_REG  = 2'b01,
    CLS_TWO_REG  = 2'b10
  } instr_class_t;

  typedef enum logic [4:0] {
    ALU_MOVE, ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR, ALU_CMP, ALU_AND, ALU_OR,
    ALU_NOT, ALU_LNOT, ALU_SHL1, ALU_SHR1, ALU_ROL1, ALU_ROR1,
    ALU_SEL_EQ, ALU_SEL_NE, ALU_SEL_GT, ALU_SEL_GE, ALU_SEL_LT, ALU_SEL_LE,
    ALU_PASS
  } alu_op_t;

  typedef enum logic [2:0] {
    FETCH, DECODE, LOAD_IMM, EXEC, WRITE_MEM, HALT
  } cycle_t;

  // ----------------------------------------------------------
  // opcode fields, two-reg 11..8, one-reg 7..4, zero-reg 4..0
  // ----------------------------------------------------------
  localparam logic [4:0] OPC_MOVE = 5'd0, OPC_ADD = 5'd1, OPC_SUB = 5'd2;
  localparam logic [4:0] OPC_SHL  = 5'd3, OPC_SHR = 5'd4, OPC_CMP = 5'd5;
  localparam logic [4:0] OPC_AND  = 5'd6, OPC_OR  = 5'd7;

  localparam logic [4:0] OPC_IMM_LOAD = 5'd0;   // with immediate
  localparam logic [4:0] OPC_MEM_LOAD = 5'd1;
  localparam logic [4:0] OPC_MEM_STORE = 5'd2;

  localparam logic [4:0] OPC_JMP_IF = 5'd0, OPC_JMP = 5'd1, OPC_JMP_REL = 5'd2;
  localparam logic [4:0] OPC_NOT  = 5'd4, OPC_LNOT = 5'd5;
  localparam logic [4:0] OPC_PUSH = 5'd6, OPC_POP  = 5'd7;
  localparam logic [4:0] OPC_SHL1 = 5'd8, OPC_SHR1 = 5'd9;
  localparam logic [4:0] OPC_ROL1 = 5'd10, OPC_ROR1 = 5'd11;

  localparam logic [4:0] OPC_HALT = 5'd0, OPC_NOP = 5'd1;
  localparam logic [4:0] OPC_SEL_EQ = 5'd4, OPC_SEL_NE = 5'd5, OPC_SEL_GT = 5'd6;
  localparam logic [4:0] OPC_SEL_GE = 5'd7, OPC_SEL_LT = 5'd8, OPC_SEL_LE = 5'd9;

endpackage

// ==== src/cpu16_regfile.sv ====
// ----------------------------------------------------------
// sixteen general registers, two combinational read ports
// and one write port, with fixed taps on pc, sp and status
// ----------------------------------------------------------
module cpu16_regfile #(
  parameter cpu16_pkg::addr_t ENTRY_ADDR = '0
) (
  input  logic                in_clk,
  input  logic                in_rst,
  input  cpu16_pkg::reg_idx_t rd_idx_a,
  input  cpu16_pkg::reg_idx_t rd_idx_b,
  output cpu16_pkg::word_t    rd_data_a,
  output cpu16_pkg::word_t    rd_data_b,
  input  logic                wr_en,
  input  cpu16_pkg::reg_idx_t wr_idx,
  input  cpu16_pkg::word_t    wr_data,
  output cpu16_pkg::word_t    pc,
  output cpu16_pkg::word_t    sp,
  output cpu16_pkg::word_t    status
);
  import cpu16_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= (i == IP_IDX) ? ENTRY_ADDR : '0;  // pc starts at entry point
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  assign pc     = regs[IP_IDX];
  assign sp     = regs[SP_IDX];
  assign status = regs[STATUS_IDX];   // flags in low bits

endmodule

// ==== src/cpu16_top.sv ====
// ----------------------------------------------------------
// top level of the 16-bit cpu, connects controller, decoder,
// alu and register file to the memory bus
// ----------------------------------------------------------
module cpu16_top #(
  parameter cpu16_pkg::addr_t ENTRY_ADDR = 16'h0000
) (
  input  logic             in_clk,
  input  logic             in_rst,
  input  logic             mem_ack,
  input  cpu16_pkg::word_t mem_rdata,
  output logic             mem_req,
  output logic             mem_write,
  output cpu16_pkg::addr_t mem_addr,
  output cpu16_pkg::word_t mem_wdata,
  output cpu16_pkg::word_t instr,
  output cpu16_pkg::addr_t pc,
  output logic             halted
);
  import cpu16_pkg::*;

  instr_class_t instr_class;
  logic         has_imm;
  logic         illegal;
  reg_idx_t     reg_a, reg_b;
  alu_op_t      alu_op;
  logic [4:0]   op_code;
  word_t        alu_result;
  reg_idx_t     rd_idx_a, rd_idx_b, wr_idx;
  word_t        rd_data_a, rd_data_b, wr_data;
  logic         wr_en;
  word_t        sp, status;

  cpu16_control i_control (
    .in_clk, .in_rst, .mem_ack, .mem_rdata, .mem_req, .mem_write, .mem_addr,
    .mem_wdata, .instr, .halted, .instr_class, .has_imm, .reg_a, .reg_b,
    .alu_op, .op_code, .illegal, .alu_result, .rd_idx_a, .rd_idx_b, .wr_en,
    .wr_idx, .wr_data, .rd_data_a, .rd_data_b, .pc, .sp
  );

  cpu16_decoder i_decoder (
    .instr, .instr_class, .has_imm, .reg_a, .reg_b, .alu_op, .op_code, .illegal
  );

  cpu16_alu i_alu (
    .alu_op, .a(rd_data_a), .b(rd_data_b), .status, .result(alu_result)
  );

  cpu16_regfile #(.ENTRY_ADDR(ENTRY_ADDR)) i_regfile (
    .in_clk, .in_rst, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wr_en, .wr_idx, .wr_data, .pc, .sp, .status
  );

endmodule

// ==== tests/cpu16_tb.sv ====
// ----------------------------------------------------------
// testbench for the 16-bit cpu, assembles small programs into
// the memory model, runs each from reset to halt and checks
// every store against a reference model of the instructions
// ----------------------------------------------------------
module cpu16_tb;
  import cpu16_pkg::*;

  localparam addr_t ENTRY        = 16'h0100;
  localparam addr_t RES          = 16'h8000;    // result area
  localparam int    NUM_PROGRAMS = 28;

  logic  in_clk, in_rst, mem_req, mem_write, mem_ack, halted, log_valid;
  addr_t mem_addr, pc, log_addr, halt_at;
  word_t mem_wdata, mem_rdata, instr, log_data, halt_word;
  int    mismatches = 0;
  int    other_errors = 0;
  int    wp = 0;                                // program write pointer
  addr_t exp_addr [$];
  word_t exp_data [$];
  logic  out_busy, out_write;                   // outstanding request
  addr_t out_addr;
  word_t out_data;

  alu_op_t    two_ops [8] = '{ALU_MOVE, ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR, ALU_CMP,
                              ALU_AND, ALU_OR};
  logic [4:0] two_opc [8] = '{OPC_MOVE, OPC_ADD, OPC_SUB, OPC_SHL, OPC_SHR, OPC_CMP,
                              OPC_AND, OPC_OR};
  alu_op_t    one_ops [6] = '{ALU_NOT, ALU_LNOT, ALU_SHL1, ALU_SHR1, ALU_ROL1, ALU_ROR1};
  logic [4:0] one_opc [6] = '{OPC_NOT, OPC_LNOT, OPC_SHL1, OPC_SHR1, OPC_ROL1, OPC_ROR1};
  alu_op_t    sel_ops [6] = '{ALU_SEL_EQ, ALU_SEL_NE, ALU_SEL_GT, ALU_SEL_GE, ALU_SEL_LT,
                              ALU_SEL_LE};
  logic [4:0] sel_opc [6] = '{OPC_SEL_EQ, OPC_SEL_NE, OPC_SEL_GT, OPC_SEL_GE, OPC_SEL_LT,
                              OPC_SEL_LE};

  cpu16_top #(.ENTRY_ADDR(ENTRY)) i_cpu16_top (
    .in_clk, .in_rst, .mem_ack, .mem_rdata, .mem_req, .mem_write, .mem_addr,
    .mem_wdata, .instr, .pc, .halted
  );

  cpu16_tb_mem i_mem (
    .in_clk, .in_rst, .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack,
    .mem_rdata, .log_valid, .log_addr, .log_data
  );

  always #50 in_clk = ~in_clk;

  // ----------------------------------------------------------
  // reference model and compare tasks
  // ----------------------------------------------------------
  function automatic word_t ref_result(alu_op_t op, word_t a, word_t b, word_t status);
    flags_t f;
    f[0] = (a == b);
    f[1] = (a != b);
    f[2] = (a > b);                             // unsigned compare
    f[3] = (a >= b);
    f[4] = (a < b);
    f[5] = (a <= b);
    case (op)
      ALU_MOVE:   return a;
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_SHL:    return (b > 15) ? 16'h0 : a << b[3:0];
      ALU_SHR:    return (b > 15) ? 16'h0 : a >> b[3:0];
      ALU_CMP:    return word_t'(f);
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_NOT:    return ~a;
      ALU_LNOT:   return (a == 0) ? 16'd1 : 16'd0;
      ALU_SHL1:   return a << 1;
      ALU_SHR1:   return a >> 1;
      ALU_ROL1:   return (a << 1) | (a >> 15);
      ALU_ROR1:   return (a >> 1) | (a << 15);
      ALU_SEL_EQ: return {status[15:1], status[0]};
      ALU_SEL_NE: return {status[15:1], status[1]};
      ALU_SEL_GT: return {status[15:1], status[2]};
      ALU_SEL_GE: return {status[15:1], status[3]};
      ALU_SEL_LT: return {status[15:1], status[4]};
      ALU_SEL_LE: return {status[15:1], status[5]};
      default:    return b;
    endcase
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // program assembly
  // ----------------------------------------------------------
  task automatic emit(input word_t w);
    i_mem.mem[ENTRY + wp] = w;
    wp++;
  endtask

  task automatic one_reg(input logic imm, input logic [4:0] opc, input reg_idx_t r);
    emit({2'b01, imm, 5'b0, opc[3:0], r});
  endtask

  task automatic two_reg(input logic [4:0] opc, input reg_idx_t ra, input reg_idx_t rb);
    emit({1'b1, 3'b0, opc[3:0], ra, rb});
  endtask

  task automatic load_imm(input reg_idx_t r, input word_t v);
    one_reg(1'b1, OPC_IMM_LOAD, r);
    emit(v);
  endtask

  task automatic store_reg(input reg_idx_t r, input addr_t a);
    one_reg(1'b1, OPC_MEM_STORE, r);
    emit(a);
  endtask

  task automatic halt_here();
    halt_at   = ENTRY + wp;
    halt_word = {11'b0, OPC_HALT};
    emit(halt_word);
  endtask

  task automatic expect_store(input addr_t a, input word_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // reset, run to halt, then watch the bus stay quiet
  task automatic run_program(input string name);
    @(posedge in_clk);
    in_rst <= 1'b1;
    repeat (8) @(posedge in_clk);
    in_rst <= 1'b0;
    while (!halted) @(posedge in_clk);
    check_addr(pc, halt_at + 16'd1, {name, ", pc after halt"});
    check_word(instr, halt_word, {name, ", instruction after halt"});
    repeat (50) begin
      @(posedge in_clk);
      if (mem_req || !halted) begin
        other_errors++;
        $display("%s: request seen or halted dropped after halt at %0t", name, $time);
      end
    end
    if (exp_addr.size() != 0) begin
      other_errors++;
      $display("%s: %0d expected stores never happened", name, exp_addr.size());
      exp_addr.delete();
      exp_data.delete();
    end
    wp = 0;
  endtask

  // ----------------------------------------------------------
  // store checker, bus protocol monitor, watchdog
  // ----------------------------------------------------------
  always @(posedge in_clk) begin
    if (log_valid) begin
      if (exp_addr.size() == 0) begin
        other_errors++;
        $display("unexpected store of %h to %h at time %0t", log_data, log_addr, $time);
      end else begin
        check_addr(log_addr, exp_addr.pop_front(), "store address");
        check_word(log_data, exp_data.pop_front(), "store data");
      end
    end
  end

  always @(posedge in_clk) begin
    if (in_rst) begin
      out_busy <= 1'b0;
    end else if (out_busy) begin
      if (out_write) begin
        check_addr(mem_addr, out_addr, "held write address");
        check_word(mem_wdata, out_data, "held write data");
        if (!mem_req) begin
          other_errors++;
          $display("write request dropped before its ack at time %0t", $time);
        end
      end else if (mem_req) begin
        other_errors++;
        $display("new request while a read is outstanding at time %0t", $time);
      end
      if (mem_ack) out_busy <= 1'b0;
    end else if (mem_req && !mem_ack) begin
      out_busy  <= 1'b1;
      out_write <= mem_write;
      out_addr  <= mem_addr;
      out_data  <= mem_wdata;
    end
  end

  initial begin
    #(NUM_PROGRAMS * 400 * 100);
    $display("watchdog expired after %0d cycles, halted never rose", NUM_PROGRAMS * 400);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // programs
  // ----------------------------------------------------------
  initial begin
    word_t a, b, v, st;
    addr_t nt_halt;
    void'($urandom(65));
    in_clk = 1'b0;
    in_rst = 1'b1;
    @(posedge in_clk);                          // memory model fills its array at time zero
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 8; i++) begin
        a = $urandom;
        b = (i == 3 || i == 4) ? word_t'($urandom_range(19, 0)) : word_t'($urandom);
        if (round == 1 && i == 5) b = a;        // equal compare
        load_imm(1, a);
        load_imm(2, b);
        two_reg(two_opc[i], 1, 2);
        store_reg((i == 0) ? reg_idx_t'(2) : (i == 5) ? STATUS_IDX : reg_idx_t'(1), RES + i);
        halt_here();
        expect_store(RES + i, ref_result(two_ops[i], a, b, 16'h0));
        run_program("two-register op");
      end
    end
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 6; i++) begin
        v = ($urandom_range(3, 0) == 0) ? 16'h0 : word_t'($urandom);
        load_imm(1, v);
        one_reg(1'b0, one_opc[i], 1);
        store_reg(1, RES + i);
        expect_store(RES + i, ref_result(one_ops[i], v, 16'h0, 16'h0));
      end
      v = $urandom;
      i_mem.mem[16'h4000] = v;                  // word for the load copy
      one_reg(1'b1, OPC_MEM_LOAD, 5);
      emit(16'h4000);
      store_reg(5, RES + 6);
      expect_store(RES + 6, v);
      halt_here();
      run_program("one-register ops and load");
    end
    for (int i = 0; i < 6; i++) begin
      a = $urandom_range(7, 0);                 // small range hits equality often
      b = $urandom_range(7, 0);
      st = ref_result(sel_ops[i], 16'h0, 16'h0, ref_result(ALU_CMP, a, b, 16'h0));
      load_imm(1, a);
      load_imm(2, b);
      two_reg(OPC_CMP, 1, 2);
      emit({11'b0, sel_opc[i]});
      store_reg(STATUS_IDX, RES);
      load_imm(3, ENTRY + 16);                  // taken path
      one_reg(1'b0, OPC_JMP_IF, 3);
      load_imm(4, 16'h00aa);
      store_reg(4, RES + 1);
      halt_here();
      nt_halt = halt_at;
      load_imm(4, 16'h0055);
      store_reg(4, RES + 1);
      halt_here();
      if (!st[0]) halt_at = nt_halt;
      expect_store(RES, st);
      expect_store(RES + 1, st[0] ? 16'h0055 : 16'h00aa);
      run_program("flag select and conditional jump");
    end
    load_imm(1, ENTRY + 5);
    one_reg(1'b0, OPC_JMP, 1);
    store_reg(0, RES + 7);                      // skipped
    load_imm(2, 16'd2);
    one_reg(1'b0, OPC_JMP_REL, 2);
    store_reg(0, RES + 7);                      // skipped
    load_imm(3, 16'h0077);
    store_reg(3, RES);
    halt_here();
    expect_store(RES, 16'h0077);
    run_program("absolute and relative jump");
    a = $urandom;
    b = $urandom;
    load_imm(1, a);
    load_imm(2, b);
    one_reg(1'b0, OPC_PUSH, 1);
    one_reg(1'b0, OPC_PUSH, 2);
    one_reg(1'b0, OPC_POP, 3);
    one_reg(1'b0, OPC_POP, 4);
    store_reg(3, RES);
    store_reg(4, RES + 1);
    store_reg(SP_IDX, RES + 2);                 // sp back at zero
    halt_here();
    expect_store(16'hffff, a);
    expect_store(16'hfffe, b);
    expect_store(RES, b);
    expect_store(RES + 1, a);
    expect_store(RES + 2, 16'h0);
    run_program("push and pop");
    emit({11'b0, OPC_NOP});
    emit({11'b0, OPC_NOP});
    halt_here();
    run_program("halt");
    emit({11'b0, OPC_NOP});
    halt_at   = ENTRY + wp;
    halt_word = {2'b01, 1'b0, 5'b0, 4'd3, 4'd0};  // call encoding, unknown opcode
    emit(halt_word);
    store_reg(0, RES);
    run_program("unknown opcode");
    $display("mismatches %0d, other errors %0d", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/cpu16_tb_mem.sv ====
// ----------------------------------------------------------
// behavioral word memory for the cpu testbench, acks each
// request 1 to 4 cycles after taking it, logs every write
// ----------------------------------------------------------
module cpu16_tb_mem (
  input  logic             in_clk,
  input  logic             in_rst,
  input  logic             mem_req,
  input  logic             mem_write,
  input  cpu16_pkg::addr_t mem_addr,
  input  cpu16_pkg::word_t mem_wdata,
  output logic             mem_ack,
  output cpu16_pkg::word_t mem_rdata,
  output logic             log_valid,
  output cpu16_pkg::addr_t log_addr,
  output cpu16_pkg::word_t log_data
);
  import cpu16_pkg::*;

  word_t mem [2**ADDR_BITS];
  logic  busy;                                  // request taken, ack pending
  logic  is_write;
  addr_t addr;
  word_t wdata;
  int    wait_cnt;

  initial begin
    for (int i = 0; i < 2**ADDR_BITS; i++) begin
      mem[i] = word_t'(i) ^ 16'h5a3c;           // pattern from the full address
    end
    mem_ack   = 1'b0;
    mem_rdata = '0;
    log_valid = 1'b0;
    log_addr  = '0;
    log_data  = '0;
  end

  always @(posedge in_clk) begin
    mem_ack   <= 1'b0;
    log_valid <= 1'b0;
    if (in_rst) begin
      busy <= 1'b0;
    end else if (busy) begin
      if (wait_cnt == 0) begin
        busy      <= 1'b0;
        mem_ack   <= 1'b1;
        mem_rdata <= mem[addr];
        if (is_write) begin
          mem[addr] <= wdata;
          log_valid <= 1'b1;                    // one log pulse per write
          log_addr  <= addr;
          log_data  <= wdata;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else if (mem_req && !mem_ack) begin     // write req still high on its ack edge
      busy     <= 1'b1;
      is_write <= mem_write;
      addr     <= mem_addr;
      wdata    <= mem_wdata;
      wait_cnt <= $urandom_range(3, 0);
    end
  end

endmodule

// ==== vlog.f ====
src/cpu16_pkg.sv
src/cpu16_regfile.sv
src/cpu16_decoder.sv
src/cpu16_alu.sv
src/cpu16_control.sv
src/cpu16_top.sv
tests/cpu16_tb_mem.sv
tests/cpu16_tb.sv
